/* include/cpu_consts.svh */
// ##################################################
// Core constants for opcodes, funct codes and register count
// ##################################################
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Opcodes
`define OP_RTYPE 6'b000000
`define OP_J     6'b000010
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_ADDI  6'b001000
`define OP_LW    6'b100011
`define OP_SW    6'b101011
`define OP_HALT  6'b111111

// R-type funct codes
`define FN_ADD 6'b100000
`define FN_SUB 6'b100010
`define FN_AND 6'b100100
`define FN_OR  6'b100101
`define FN_SLT 6'b101010

`define NUM_REGS 32

`endif

/* src/cpu_types_pkg.sv */
// ##################################################
// Shared datapath types for the pipelined core
// ##################################################
package cpu_types_pkg;

  // Data and address word
  typedef logic [31:0] word_t;

  // Register index
  typedef logic [4:0] regbits_t;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } aluop_t;

  // Source of an execute operand
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_t;

endpackage

/* src/register_file.sv */
// ##################################################
// 32 x 32 register file with write-through reads
// ##################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  word_t regs [`NUM_REGS];
  logic  wr_ok;

  // Register 0 is never written
  assign wr_ok = wen && (wsel != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_ok) begin
      regs[wsel] <= wdat;
    end
  end

  // Same-cycle write shows up on the read ports
  assign rdat1 = (wr_ok && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wr_ok && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

/* src/fetch_stage.sv */
// ##################################################
// Fetch stage with PC, instruction request and F/D latch
// ##################################################
`timescale 1ns/1ps

module fetch_stage #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imemload,
  input  logic                 freeze,
  input  logic                 flush,
  input  logic                 branch_taken,
  input  cpu_types_pkg::word_t branch_target,
  input  logic                 halt_e,
  output logic                 imemREN,
  output cpu_types_pkg::word_t imemaddr,
  output cpu_types_pkg::word_t instr_f,
  output cpu_types_pkg::word_t npc_f
);
  import cpu_types_pkg::*;

  word_t pc;
  word_t pc_plus4;

  assign pc_plus4 = pc + 32'd4;
  assign imemaddr = pc;
  // Stop fetching once halt is in execute
  assign imemREN = !halt_e;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (!freeze) begin
      if (branch_taken) begin
        pc <= branch_target;
      end else if (ihit) begin
        pc <= pc_plus4;
      end
    end
  end

  // A zero word decodes as a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      instr_f <= '0;
    end else if (!freeze) begin
      instr_f <= (flush || !ihit) ? '0 : imemload;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      npc_f <= pc_plus4;
    end
  end

  // Memory sees a steady address until it answers
  assert property (@(posedge CLK) disable iff (!nRST)
    imemREN && !ihit |=> $stable(imemaddr));

endmodule

/* src/decode_stage.sv */
// ##################################################
// Decode stage with control, register read and D/E latch
// ##################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module decode_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::word_t    instr_f,
  input  cpu_types_pkg::word_t    npc_f,
  input  logic                    freeze,
  input  logic                    flush,
  input  logic                    wb_wen,
  input  cpu_types_pkg::regbits_t wb_reg,
  input  cpu_types_pkg::word_t    wb_data,
  output cpu_types_pkg::regbits_t rs_d,
  output cpu_types_pkg::regbits_t rt_d,
  output cpu_types_pkg::regbits_t rw_d,
  output cpu_types_pkg::word_t    rdat1_d,
  output cpu_types_pkg::word_t    rdat2_d,
  output cpu_types_pkg::word_t    imm_d,
  output cpu_types_pkg::word_t    npc_d,
  output cpu_types_pkg::word_t    jaddr_d,
  output cpu_types_pkg::aluop_t   aluop_d,
  output logic                    alusrc_d,
  output logic                    dren_d,
  output logic                    dwen_d,
  output logic                    regwen_d,
  output logic                    beq_d,
  output logic                    bne_d,
  output logic                    jump_d,
  output logic                    halt_d
);
  import cpu_types_pkg::*;

  logic [5:0] op;
  logic [5:0] funct;
  regbits_t   rs;
  regbits_t   rt;
  regbits_t   rw;
  word_t      rdat1;
  word_t      rdat2;
  aluop_t     aluop;
  logic       alusrc;
  logic       dren;
  logic       dwen;
  logic       regwen;
  logic       beq;
  logic       bne;
  logic       jump;
  logic       halt;

  assign op    = instr_f[31:26];
  assign funct = instr_f[5:0];
  assign rs    = instr_f[25:21];
  assign rt    = instr_f[20:16];

  register_file i_register_file (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (wb_wen),
    .wsel  (wb_reg),
    .wdat  (wb_data),
    .rsel1 (rs),
    .rsel2 (rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // Unknown encodings fall through as a bubble
  always_comb begin
    rw     = rt;
    aluop  = ALU_ADD;
    alusrc = 1'b0;
    dren   = 1'b0;
    dwen   = 1'b0;
    regwen = 1'b0;
    beq    = 1'b0;
    bne    = 1'b0;
    jump   = 1'b0;
    halt   = 1'b0;
    case (op)
      `OP_RTYPE: begin
        rw     = instr_f[15:11];
        regwen = 1'b1;
        case (funct)
          `FN_ADD: aluop = ALU_ADD;
          `FN_SUB: aluop = ALU_SUB;
          `FN_AND: aluop = ALU_AND;
          `FN_OR:  aluop = ALU_OR;
          `FN_SLT: aluop = ALU_SLT;
          default: regwen = 1'b0;
        endcase
      end
      `OP_ADDI: begin
        alusrc = 1'b1;
        regwen = 1'b1;
      end
      `OP_LW: begin
        alusrc = 1'b1;
        dren   = 1'b1;
        regwen = 1'b1;
      end
      `OP_SW: begin
        alusrc = 1'b1;
        dwen   = 1'b1;
      end
      `OP_BEQ: begin
        aluop = ALU_SUB;
        beq   = 1'b1;
      end
      `OP_BNE: begin
        aluop = ALU_SUB;
        bne   = 1'b1;
      end
      `OP_J:    jump = 1'b1;
      `OP_HALT: halt = 1'b1;
      default:  ;
    endcase
  end

  // D/E control
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {dren_d, dwen_d, regwen_d, beq_d, bne_d, jump_d, halt_d} <= '0;
    end else if (!freeze) begin
      if (flush) begin
        {dren_d, dwen_d, regwen_d, beq_d, bne_d, jump_d, halt_d} <= '0;
      end else begin
        {dren_d, dwen_d, regwen_d, beq_d, bne_d, jump_d, halt_d} <=
          {dren, dwen, regwen, beq, bne, jump, halt};
      end
    end
  end

  // D/E payload
  always_ff @(posedge CLK) begin
    if (!freeze) begin
      rs_d     <= rs;
      rt_d     <= rt;
      rw_d     <= rw;
      rdat1_d  <= rdat1;
      rdat2_d  <= rdat2;
      imm_d    <= {{16{instr_f[15]}}, instr_f[15:0]};
      npc_d    <= npc_f;
      jaddr_d  <= {npc_f[31:28], instr_f[25:0], 2'b00};
      aluop_d  <= aluop;
      alusrc_d <= alusrc;
    end
  end

endmodule

/* src/execute_stage.sv */
// ##################################################
// Execute stage with operand forwarding, ALU and targets
// ##################################################
`timescale 1ns/1ps

module execute_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::regbits_t rw_d,
  input  cpu_types_pkg::word_t    rdat1_d,
  input  cpu_types_pkg::word_t    rdat2_d,
  input  cpu_types_pkg::word_t    imm_d,
  input  cpu_types_pkg::word_t    npc_d,
  input  cpu_types_pkg::word_t    jaddr_d,
  input  cpu_types_pkg::aluop_t   aluop_d,
  input  logic                    alusrc_d,
  input  logic                    dren_d,
  input  logic                    dwen_d,
  input  logic                    regwen_d,
  input  logic                    beq_d,
  input  logic                    bne_d,
  input  logic                    jump_d,
  input  logic                    halt_d,
  input  cpu_types_pkg::fwd_sel_t fwd_a,
  input  cpu_types_pkg::fwd_sel_t fwd_b,
  input  cpu_types_pkg::word_t    wb_data,
  input  logic                    freeze,
  input  logic                    flush,
  output cpu_types_pkg::word_t    alu_out_e,
  output cpu_types_pkg::word_t    store_e,
  output cpu_types_pkg::word_t    target_e,
  output cpu_types_pkg::regbits_t rw_e,
  output logic                    zero_e,
  output logic                    dren_e,
  output logic                    dwen_e,
  output logic                    regwen_e,
  output logic                    beq_e,
  output logic                    bne_e,
  output logic                    jump_e,
  output logic                    halt_e
);
  import cpu_types_pkg::*;

  word_t opa;
  word_t opb_reg;
  word_t opb;
  word_t alu_res;
  logic  hold;

  // Operand A and the register form of operand B
  always_comb begin
    case (fwd_a)
      FWD_MEM: opa = alu_out_e;
      FWD_WB:  opa = wb_data;
      default: opa = rdat1_d;
    endcase
    case (fwd_b)
      FWD_MEM: opb_reg = alu_out_e;
      FWD_WB:  opb_reg = wb_data;
      default: opb_reg = rdat2_d;
    endcase
  end

  assign opb = alusrc_d ? imm_d : opb_reg;

  always_comb begin
    case (aluop_d)
      ALU_SUB: alu_res = opa - opb;
      ALU_AND: alu_res = opa & opb;
      ALU_OR:  alu_res = opa | opb;
      ALU_SLT: alu_res = {31'b0, $signed(opa) < $signed(opb)};
      default: alu_res = opa + opb;
    endcase
  end

  // A halt parks here for good so nothing younger reaches memory
  assign hold = freeze || halt_e;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {dren_e, dwen_e, regwen_e, beq_e, bne_e, jump_e, halt_e} <= '0;
    end else if (!hold) begin
      if (flush) begin
        {dren_e, dwen_e, regwen_e, beq_e, bne_e, jump_e, halt_e} <= '0;
      end else begin
        {dren_e, dwen_e, regwen_e, beq_e, bne_e, jump_e, halt_e} <=
          {dren_d, dwen_d, regwen_d, beq_d, bne_d, jump_d, halt_d};
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!hold) begin
      alu_out_e <= alu_res;
      store_e   <= opb_reg;
      target_e  <= jump_d ? jaddr_d : npc_d + (imm_d << 2);
      rw_e      <= rw_d;
      zero_e    <= (alu_res == '0);
    end
  end

endmodule

/* src/memory_stage.sv */
// ##################################################
// Memory stage with data request, branch resolve and M/W latch
// ##################################################
`timescale 1ns/1ps

module memory_stage (
  input  logic                    CLK,
  input  logic                    nRST,
  input  cpu_types_pkg::word_t    alu_out_e,
  input  cpu_types_pkg::word_t    store_e,
  input  cpu_types_pkg::word_t    target_e,
  input  cpu_types_pkg::regbits_t rw_e,
  input  logic                    zero_e,
  input  logic                    dren_e,
  input  logic                    dwen_e,
  input  logic                    regwen_e,
  input  logic                    beq_e,
  input  logic                    bne_e,
  input  logic                    jump_e,
  input  logic                    halt_e,
  input  logic                    dhit,
  input  cpu_types_pkg::word_t    dmemload,
  input  logic                    freeze,
  input  logic                    flush,
  output logic                    dmemREN,
  output logic                    dmemWEN,
  output cpu_types_pkg::word_t    dmemaddr,
  output cpu_types_pkg::word_t    dmemstore,
  output logic                    branch_taken,
  output cpu_types_pkg::word_t    branch_target,
  output logic                    mem_wait,
  output logic                    wb_wen,
  output cpu_types_pkg::regbits_t wb_reg,
  output cpu_types_pkg::word_t    wb_data,
  output logic                    halt_m
);
  assign dmemREN   = dren_e;
  assign dmemWEN   = dwen_e;
  assign dmemaddr  = alu_out_e;
  assign dmemstore = store_e;
  assign mem_wait  = (dren_e || dwen_e) && !dhit;

  assign branch_taken  = jump_e || (beq_e && zero_e) || (bne_e && !zero_e);
  assign branch_target = target_e;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wb_wen <= 1'b0;
      halt_m <= 1'b0;
    end else if (!freeze) begin
      wb_wen <= flush ? 1'b0 : regwen_e;
      halt_m <= flush ? 1'b0 : halt_e;
    end
  end

  always_ff @(posedge CLK) begin
    if (!freeze) begin
      wb_reg  <= rw_e;
      wb_data <= dren_e ? dmemload : alu_out_e;
    end
  end

  assert property (@(posedge CLK) disable iff (!nRST)
    !(dmemREN && dmemWEN));

  // Pipeline freeze keeps the request steady until dhit
  assert property (@(posedge CLK) disable iff (!nRST)
    (dmemREN || dmemWEN) && !dhit |=> $stable(dmemaddr) && $stable(dmemstore));

endmodule

/* src/hazard_unit.sv */
// ##################################################
// Hazard unit driving per-stage flush and freeze
// ##################################################
`timescale 1ns/1ps

module hazard_unit (
  input  cpu_types_pkg::word_t    instr_f,
  input  logic                    dren_d,
  input  cpu_types_pkg::regbits_t rw_d,
  input  logic                    mem_wait,
  input  logic                    ihit,
  input  logic                    imemREN,
  input  logic                    branch_taken,
  output logic [3:0]              flush,
  output logic [3:0]              freeze
);
  logic load_use;

  // Load in decode latch feeding the instruction being decoded
  assign load_use = dren_d && (rw_d != '0) &&
                    ((rw_d == instr_f[25:21]) || (rw_d == instr_f[20:16]));

  always_comb begin
    flush  = 4'b0000;
    freeze = 4'b0000;
    if (mem_wait) begin
      freeze = 4'b1111;
    end else if (branch_taken) begin
      // Redirect waits for the pending fetch to finish
      if (imemREN && !ihit) begin
        freeze = 4'b1111;
      end else begin
        flush = 4'b1110;
      end
    end else if (load_use) begin
      freeze = 4'b1000;
      flush  = 4'b0100;
    end else if (!ihit) begin
      freeze = 4'b1000;
      flush  = 4'b0100;
    end
  end

endmodule

/* src/forwarding_unit.sv */
// ##################################################
// Forwarding unit selecting execute operand sources
// ##################################################
`timescale 1ns/1ps

module forwarding_unit (
  input  cpu_types_pkg::regbits_t rs_d,
  input  cpu_types_pkg::regbits_t rt_d,
  input  cpu_types_pkg::regbits_t rw_e,
  input  cpu_types_pkg::regbits_t rw_m,
  input  logic                    regwen_e,
  input  logic                    regwen_m,
  output cpu_types_pkg::fwd_sel_t fwd_a,
  output cpu_types_pkg::fwd_sel_t fwd_b
);
  import cpu_types_pkg::*;

  logic wr_e;
  logic wr_m;

  // Writes to register 0 never forward
  assign wr_e = regwen_e && (rw_e != '0);
  assign wr_m = regwen_m && (rw_m != '0);

  // Nearest producer wins
  assign fwd_a = (wr_e && rw_e == rs_d) ? FWD_MEM :
                 (wr_m && rw_m == rs_d) ? FWD_WB  : FWD_REG;
  assign fwd_b = (wr_e && rw_e == rt_d) ? FWD_MEM :
                 (wr_m && rw_m == rt_d) ? FWD_WB  : FWD_REG;

endmodule

/* src/datapath.sv */
// ##################################################
// Pipelined core top with stages, hazard and forwarding
// ##################################################
`timescale 1ns/1ps

module datapath #(
  parameter cpu_types_pkg::word_t PC_INIT = '0
) (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imemload,
  output logic                 imemREN,
  output cpu_types_pkg::word_t imemaddr,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 halt
);
  import cpu_types_pkg::*;

  logic [3:0] flush;
  logic [3:0] freeze;

  // Fetch to decode
  word_t instr_f;
  word_t npc_f;

  // Decode to execute
  regbits_t rs_d;
  regbits_t rt_d;
  regbits_t rw_d;
  word_t    rdat1_d;
  word_t    rdat2_d;
  word_t    imm_d;
  word_t    npc_d;
  word_t    jaddr_d;
  aluop_t   aluop_d;
  logic     alusrc_d;
  logic     dren_d;
  logic     dwen_d;
  logic     regwen_d;
  logic     beq_d;
  logic     bne_d;
  logic     jump_d;
  logic     halt_d;

  // Execute to memory
  word_t    alu_out_e;
  word_t    store_e;
  word_t    target_e;
  regbits_t rw_e;
  logic     zero_e;
  logic     dren_e;
  logic     dwen_e;
  logic     regwen_e;
  logic     beq_e;
  logic     bne_e;
  logic     jump_e;
  logic     halt_e;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;

  // Memory outputs and writeback
  logic     branch_taken;
  word_t    branch_target;
  logic     mem_wait;
  logic     wb_wen;
  regbits_t wb_reg;
  word_t    wb_data;
  logic     halt_m;

  fetch_stage #(.PC_INIT(PC_INIT)) i_fetch_stage (
    .freeze (freeze[3]),
    .flush  (flush[3]),
    .*
  );

  decode_stage i_decode_stage (
    .freeze (freeze[2]),
    .flush  (flush[2]),
    .*
  );

  execute_stage i_execute_stage (
    .freeze (freeze[1]),
    .flush  (flush[1]),
    .*
  );

  memory_stage i_memory_stage (
    .freeze (freeze[0]),
    .flush  (flush[0]),
    .*
  );

  hazard_unit i_hazard_unit (.*);

  forwarding_unit i_forwarding_unit (
    .rs_d     (rs_d),
    .rt_d     (rt_d),
    .rw_e     (rw_e),
    .rw_m     (wb_reg),
    .regwen_e (regwen_e),
    .regwen_m (wb_wen),
    .fwd_a    (fwd_a),
    .fwd_b    (fwd_b)
  );

  // Sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (halt_m) begin
      halt <= 1'b1;
    end
  end

endmodule

/* testbench/tb_datapath.sv */
// ##################################################
// Testbench for the pipelined core with memory model,
// reference ISA model and store checking
// ##################################################
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_datapath;
  import cpu_types_pkg::*;

  localparam word_t PC_INIT = 32'h0000_0000;

  logic  CLK;
  logic  nRST;
  logic  ihit;
  word_t imemload;
  logic  imemREN;
  word_t imemaddr;
  logic  dhit;
  word_t dmemload;
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  halt;

  word_t imem [64];
  word_t dmem [64];
  word_t exp_addr [$];
  word_t exp_data [$];
  word_t halt_pc;
  int    i_wait;
  int    d_wait;
  logic  halt_seen;
  logic  i_pend;
  logic  d_pend;
  word_t i_addr_prev;
  word_t d_addr_prev;
  word_t d_store_prev;

  datapath #(.PC_INIT(PC_INIT)) i_dut (.*);

  always #4 CLK = ~CLK;

  task automatic stop_with_failure();
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, expected);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    if (got !== expected) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, got, expected);
      stop_with_failure();
    end
  endtask

  // Initial data word depends on the full byte address
  function automatic word_t fill_word(input int idx);
    word_t addr;
    addr = word_t'(idx) << 2;
    return (addr * 32'h0001_0003) ^ 32'hA5A5_0000;
  endfunction

  function automatic word_t enc_r(input regbits_t rs, input regbits_t rt,
                                  input regbits_t rd, input logic [5:0] fn);
    return {`OP_RTYPE, rs, rt, rd, 5'b00000, fn};
  endfunction

  function automatic word_t enc_i(input logic [5:0] op, input regbits_t rs,
                                  input regbits_t rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Instruction-level model that returns the halt address
  function automatic word_t run_reference();
    word_t regs [`NUM_REGS];
    word_t mem [64];
    word_t pc;
    word_t npc;
    word_t ins;
    word_t a;
    word_t b;
    word_t imm;
    regbits_t rt;
    regbits_t rd;
    for (int i = 0; i < `NUM_REGS; i++) regs[i] = '0;
    for (int i = 0; i < 64; i++) mem[i] = fill_word(i);
    pc = PC_INIT;
    for (int step = 0; step < 1000; step++) begin
      ins = imem[pc[7:2]];
      a   = regs[ins[25:21]];
      b   = regs[ins[20:16]];
      rt  = ins[20:16];
      rd  = ins[15:11];
      imm = {{16{ins[15]}}, ins[15:0]};
      npc = pc + 32'd4;
      case (ins[31:26])
        `OP_RTYPE: begin
          case (ins[5:0])
            `FN_ADD: if (rd != '0) regs[rd] = a + b;
            `FN_SUB: if (rd != '0) regs[rd] = a - b;
            `FN_AND: if (rd != '0) regs[rd] = a & b;
            `FN_OR:  if (rd != '0) regs[rd] = a | b;
            `FN_SLT: if (rd != '0) regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: ;
          endcase
        end
        `OP_ADDI: if (rt != '0) regs[rt] = a + imm;
        `OP_LW:   if (rt != '0) regs[rt] = mem[(a + imm) >> 2];
        `OP_SW: begin
          mem[(a + imm) >> 2] = b;
          exp_addr.push_back(a + imm);
          exp_data.push_back(b);
        end
        `OP_BEQ:  if (a == b) npc = npc + (imm << 2);
        `OP_BNE:  if (a != b) npc = npc + (imm << 2);
        `OP_J:    npc = {npc[31:28], ins[25:0], 2'b00};
        `OP_HALT: return pc;
        default:  ;
      endcase
      pc = npc;
    end
    return '1;
  endfunction

  // Program covering ALU ops, forwarding, load-use, branches, jump and halt
  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;
      dmem[i] = fill_word(i);
    end
    imem[0]  = enc_i(`OP_ADDI, 5'd0, 5'd1, 16'd7);
    imem[1]  = enc_i(`OP_ADDI, 5'd0, 5'd2, 16'hFFFD);
    imem[2]  = enc_r(5'd1, 5'd2, 5'd3, `FN_ADD);
    imem[3]  = enc_r(5'd3, 5'd1, 5'd4, `FN_SUB);
    imem[4]  = enc_r(5'd4, 5'd1, 5'd5, `FN_AND);
    imem[5]  = enc_r(5'd5, 5'd2, 5'd6, `FN_OR);
    imem[6]  = enc_r(5'd2, 5'd1, 5'd7, `FN_SLT);
    imem[7]  = enc_i(`OP_SW, 5'd0, 5'd3, 16'h0040);
    imem[8]  = enc_i(`OP_SW, 5'd0, 5'd4, 16'h0044);
    imem[9]  = enc_i(`OP_SW, 5'd0, 5'd5, 16'h0048);
    imem[10] = enc_i(`OP_SW, 5'd0, 5'd6, 16'h004C);
    imem[11] = enc_i(`OP_SW, 5'd0, 5'd7, 16'h0050);
    imem[12] = enc_i(`OP_LW, 5'd0, 5'd8, 16'h0010);
    imem[13] = enc_r(5'd8, 5'd1, 5'd9, `FN_ADD);
    imem[14] = enc_i(`OP_SW, 5'd0, 5'd9, 16'h0054);
    imem[15] = enc_i(`OP_BEQ, 5'd1, 5'd1, 16'd2);
    imem[16] = enc_i(`OP_SW, 5'd0, 5'd1, 16'h0058);
    imem[17] = enc_i(`OP_SW, 5'd0, 5'd2, 16'h005C);
    imem[18] = enc_i(`OP_BNE, 5'd1, 5'd1, 16'd5);
    imem[19] = enc_i(`OP_BEQ, 5'd1, 5'd2, 16'd5);
    imem[20] = enc_i(`OP_BNE, 5'd1, 5'd2, 16'd2);
    imem[21] = enc_i(`OP_SW, 5'd0, 5'd1, 16'h0060);
    imem[22] = enc_i(`OP_ADDI, 5'd0, 5'd1, 16'd99);
    imem[23] = enc_i(`OP_SW, 5'd0, 5'd1, 16'h0064);
    imem[24] = {`OP_J, 26'd27};
    imem[25] = enc_i(`OP_SW, 5'd0, 5'd2, 16'h0068);
    imem[26] = enc_i(`OP_ADDI, 5'd0, 5'd3, 16'd5);
    imem[27] = enc_i(`OP_LW, 5'd0, 5'd10, 16'h0040);
    imem[28] = enc_r(5'd10, 5'd8, 5'd11, `FN_SUB);
    imem[29] = enc_i(`OP_SW, 5'd0, 5'd11, 16'h006C);
    imem[30] = {`OP_HALT, 26'd0};
  endtask

  // Memory model with a random latency of 0 to 3 cycles per request
  always @(posedge CLK) begin
    #1;
    if (!nRST || !imemREN) begin
      ihit   = 1'b0;
      i_wait = -1;
    end else begin
      if (i_wait < 0) i_wait = int'($urandom % 4);
      if (i_wait == 0) begin
        ihit     = 1'b1;
        imemload = imem[imemaddr[7:2]];
        i_wait   = -1;
      end else begin
        ihit   = 1'b0;
        i_wait = i_wait - 1;
      end
    end
    if (!nRST || !(dmemREN || dmemWEN)) begin
      dhit   = 1'b0;
      d_wait = -1;
    end else begin
      if (d_wait < 0) d_wait = int'($urandom % 4);
      if (d_wait == 0) begin
        dhit     = 1'b1;
        dmemload = dmem[dmemaddr[7:2]];
        if (dmemWEN) dmem[dmemaddr[7:2]] = dmemstore;
        d_wait   = -1;
      end else begin
        dhit   = 1'b0;
        d_wait = d_wait - 1;
      end
    end
  end

  // Compares at the falling edge
  always @(negedge CLK) begin
    if (nRST) begin
      check_flag("dmemREN and dmemWEN together", dmemREN && dmemWEN, 1'b0);
      if (i_pend) check_word("imemaddr", imemaddr, i_addr_prev);
      if (d_pend) begin
        check_word("dmemaddr", dmemaddr, d_addr_prev);
        check_word("dmemstore", dmemstore, d_store_prev);
      end
      if (dmemWEN && dhit) begin
        if (exp_addr.size() == 0) begin
          $display("Store to %h at %0t was not expected", dmemaddr, $time);
          stop_with_failure();
        end else begin
          check_word("dmemaddr", dmemaddr, exp_addr.pop_front());
          check_word("dmemstore", dmemstore, exp_data.pop_front());
        end
      end
      if (halt) halt_seen = 1'b1;
      if (halt_seen) begin
        check_flag("halt", halt, 1'b1);
        check_flag("imemREN", imemREN, 1'b0);
        check_flag("dmemWEN", dmemWEN, 1'b0);
      end
      i_pend       = imemREN && !ihit;
      i_addr_prev  = imemaddr;
      d_pend       = (dmemREN || dmemWEN) && !dhit;
      d_addr_prev  = dmemaddr;
      d_store_prev = dmemstore;
    end
  end

  initial begin
    int cycles;
    void'($urandom(6));
    CLK       = 1'b0;
    nRST      = 1'b0;
    ihit      = 1'b0;
    dhit      = 1'b0;
    imemload  = '0;
    dmemload  = '0;
    halt_seen = 1'b0;
    i_pend    = 1'b0;
    d_pend    = 1'b0;
    i_wait    = -1;
    d_wait    = -1;
    load_program();
    halt_pc = run_reference();
    repeat (10) @(posedge CLK);
    #1 nRST <= 1'b1;
    cycles = 0;
    while (!halt && cycles < 5000) begin
      @(negedge CLK);
      cycles++;
    end
    if (!halt) begin
      $display("Timeout: the core never raised halt");
      stop_with_failure();
    end else begin
      // Quiet period to catch any late store
      cycles = 0;
      while (cycles < 20) begin
        @(negedge CLK);
        cycles++;
      end
      check_flag("fetch stopped just past halt",
                 (imemaddr > halt_pc) && (imemaddr <= halt_pc + 32'd12), 1'b1);
      if (exp_addr.size() != 0) begin
        $display("%0d expected stores never reached memory", exp_addr.size());
        stop_with_failure();
      end else begin
        $display("SIMULATION PASSED");
        $finish;
      end
    end
  end

endmodule

/* sources.f */
+incdir+include
src/cpu_types_pkg.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/hazard_unit.sv
src/forwarding_unit.sv
src/datapath.sv
testbench/tb_datapath.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_datapath
FILELIST  = sources.f
BUILD     = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: compile
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(BUILD)
